//--- sources.f
hw/lsq_pkg.sv
hw/lq_entry.sv
hw/sq_entry.sv
hw/load_queue.sv
hw/store_queue.sv
hw/lsq_arbiter.sv
hw/lsq_top.sv
verification/lsq_properties.sv
verification/lsq_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the LSQ testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lsq_tb -f sources.f -o lsq_sim \
	&& ./obj_dir/lsq_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "^Test OK$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verification/lsq_tb.sv
// LSQ testbench
// Directed tests for load issue, store report and commit, store to load
// ordering, and the full flag with a mispredict flush
`timescale 1ns/1ps

module lsq_tb import lsq_pkg::*; ();
	logic     clock;
	logic     reset;
	logic     dispatch_valid;
	mem_op_t  dispatch_op;
	word_t    dispatch_base;
	logic     dispatch_base_ready;
	word_t    dispatch_offset;
	word_t    dispatch_data;
	logic     dispatch_data_ready;
	rob_idx_t dispatch_rob_idx;
	tag_t     dispatch_dest_tag;
	logic     cdb_valid;
	tag_t     cdb_tag;
	word_t    cdb_value;
	logic     retire_valid;
	rob_idx_t retire_rob_idx;
	logic     mispredict;
	bus_cmd_t mem_command;
	word_t    mem_address;
	word_t    mem_wdata;
	logic     mem_ack;
	word_t    mem_rdata;
	logic     result_valid;
	rob_idx_t result_rob_idx;
	tag_t     result_tag;
	word_t    result_value;
	logic     lsq_full;

	int error_count;
	int timeout_count;

	lsq_top uut (.*);

	bind lsq_top lsq_properties u_properties (
		.clock          (clock),
		.reset          (reset),
		.mispredict     (mispredict),
		.dispatch_valid (dispatch_valid),
		.lsq_full       (lsq_full),
		.mem_ack        (mem_ack),
		.mem_command    (mem_command),
		.mem_address    (mem_address),
		.result_valid   (result_valid)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic check_word(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_tag(input string name, input tag_t actual, input tag_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic check_rob(input string name, input rob_idx_t actual, input rob_idx_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic check_cmd(input string name, input bus_cmd_t actual, input bus_cmd_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t: %s = %s, expected %s", $time, name, actual.name(),
				expected.name());
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
		end
	endtask

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////
	task automatic tick();
		@(posedge clock);
		#4; // Inputs change a few ns after the edge
	endtask

	function automatic word_t random_word();
		return {$urandom(), $urandom()};
	endfunction

	task automatic dispatch(input mem_op_t op, input word_t base, input logic base_ready,
		input word_t offset, input word_t data, input logic data_ready,
		input rob_idx_t rob, input tag_t dest);
		if (lsq_full) begin
			error_count++;
			$display("Dispatch at %0t skipped because the LSQ reports full", $time);
		end else begin
			dispatch_valid      = 1'b1;
			dispatch_op         = op;
			dispatch_base       = base;
			dispatch_base_ready = base_ready;
			dispatch_offset     = offset;
			dispatch_data       = data;
			dispatch_data_ready = data_ready;
			dispatch_rob_idx    = rob;
			dispatch_dest_tag   = dest;
			tick();
			dispatch_valid = 1'b0;
			dispatch_op    = op_none;
		end
	endtask

	task automatic broadcast(input tag_t tag, input word_t value);
		cdb_valid = 1'b1;
		cdb_tag   = tag;
		cdb_value = value;
		tick();
		cdb_valid = 1'b0;
	endtask

	task automatic retire(input rob_idx_t rob);
		retire_valid   = 1'b1;
		retire_rob_idx = rob;
		tick();
		retire_valid = 1'b0;
	endtask

	task automatic ack_memory(input word_t data);
		mem_ack   = 1'b1;
		mem_rdata = data;
		tick();
		mem_ack   = 1'b0;
		mem_rdata = '0;
	endtask

	// Any other request seen first is an ordering error
	task automatic wait_cmd(input bus_cmd_t expected);
		int cycles;
		cycles = 0;
		while (mem_command !== expected && cycles < 20) begin
			if (mem_command !== bus_none) begin
				error_count++;
				$display("Unexpected %s request at %0t while waiting for %s",
					mem_command.name(), $time, expected.name());
			end
			tick();
			cycles++;
		end
		if (mem_command !== expected) begin
			timeout_count++;
			$display("Timeout: no %s request after %0d cycles", expected.name(), cycles);
		end
	endtask

	task automatic wait_result();
		int cycles;
		cycles = 0;
		while (result_valid !== 1'b1 && cycles < 20) begin
			tick();
			cycles++;
		end
		if (result_valid !== 1'b1) begin
			timeout_count++;
			$display("Timeout: result port stayed idle for %0d cycles", cycles);
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic test_reset_state();
		check_cmd("mem_command", mem_command, bus_none);
		check_bit("result_valid", result_valid, 1'b0);
		check_bit("lsq_full", lsq_full, 1'b0);
	endtask

	task automatic test_load_issue();
		word_t base;
		word_t offset;
		word_t rdata;
		base   = random_word();
		offset = word_t'($urandom() & 32'hff);
		rdata  = random_word();
		dispatch(op_load, base, 1'b1, offset, '0, 1'b1, 5'd1, 6'd33);
		check_cmd("mem_command", mem_command, bus_load); // One cycle after dispatch
		check_word("mem_address", mem_address, base + offset);
		ack_memory(rdata);
		check_bit("result_valid", result_valid, 1'b1);
		check_word("result_value", result_value, rdata);
		check_tag("result_tag", result_tag, 6'd33);
		check_rob("result_rob_idx", result_rob_idx, 5'd1);
		check_cmd("mem_command", mem_command, bus_none);
		tick();
		check_bit("result_valid", result_valid, 1'b0);
	endtask

	task automatic test_store_report();
		word_t base;
		word_t offset;
		word_t data;
		base   = random_word();
		offset = word_t'($urandom() & 32'hff);
		data   = random_word();
		// Base waits on tag 12 and data on tag 13
		dispatch(op_store, word_t'(6'd12), 1'b0, offset, word_t'(6'd13), 1'b0, 5'd2, 6'd0);
		repeat (2) begin
			check_bit("result_valid", result_valid, 1'b0);
			check_cmd("mem_command", mem_command, bus_none);
			tick();
		end
		broadcast(6'd12, base);
		broadcast(6'd13, data);
		wait_result();
		check_word("result_value", result_value, base + offset);
		check_tag("result_tag", result_tag, 6'd0);
		check_rob("result_rob_idx", result_rob_idx, 5'd2);
		tick();
		check_bit("result_valid", result_valid, 1'b0); // Reported once only
		retire(5'd2);
		wait_cmd(bus_store);
		check_word("mem_address", mem_address, base + offset);
		check_word("mem_wdata", mem_wdata, data);
		ack_memory('0);
		check_cmd("mem_command", mem_command, bus_none);
	endtask

	task automatic test_store_load_order();
		word_t st_base;
		word_t st_offset;
		word_t st_data;
		word_t ld_base;
		word_t ld_offset;
		word_t rdata;
		st_base   = random_word();
		st_offset = word_t'($urandom() & 32'hff);
		st_data   = random_word();
		ld_base   = random_word();
		ld_offset = word_t'($urandom() & 32'hff);
		rdata     = random_word();
		dispatch(op_store, st_base, 1'b1, st_offset, st_data, 1'b1, 5'd3, 6'd0);
		wait_result();
		check_word("result_value", result_value, st_base + st_offset);
		dispatch(op_load, ld_base, 1'b1, ld_offset, '0, 1'b1, 5'd4, 6'd40);
		// Older store still unretired
		repeat (4) begin
			check_cmd("mem_command", mem_command, bus_none);
			tick();
		end
		retire(5'd3);
		wait_cmd(bus_store);
		check_word("mem_address", mem_address, st_base + st_offset);
		check_word("mem_wdata", mem_wdata, st_data);
		ack_memory('0);
		wait_cmd(bus_load);
		check_word("mem_address", mem_address, ld_base + ld_offset);
		ack_memory(rdata);
		check_bit("result_valid", result_valid, 1'b1);
		check_word("result_value", result_value, rdata);
		check_tag("result_tag", result_tag, 6'd40);
		check_rob("result_rob_idx", result_rob_idx, 5'd4);
		tick();
	endtask

	task automatic test_full_flush();
		word_t base;
		base = random_word();
		for (int i = 0; i < LQ_DEPTH; i++)
			dispatch(op_load, base, 1'b1, word_t'(i * 8), '0, 1'b1, rob_idx_t'(8 + i), tag_t'(i));
		check_bit("lsq_full", lsq_full, 1'b1);
		check_cmd("mem_command", mem_command, bus_load); // First load still unacknowledged
		mispredict = 1'b1;
		tick();
		mispredict = 1'b0;
		check_bit("lsq_full", lsq_full, 1'b0);
		check_cmd("mem_command", mem_command, bus_none);
		check_bit("result_valid", result_valid, 1'b0);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		error_count   = 0;
		timeout_count = 0;
		void'($urandom(28));
		reset               = 1'b1;
		dispatch_valid      = 1'b0;
		dispatch_op         = op_none;
		dispatch_base       = '0;
		dispatch_base_ready = 1'b0;
		dispatch_offset     = '0;
		dispatch_data       = '0;
		dispatch_data_ready = 1'b0;
		dispatch_rob_idx    = '0;
		dispatch_dest_tag   = '0;
		cdb_valid           = 1'b0;
		cdb_tag             = '0;
		cdb_value           = '0;
		retire_valid        = 1'b0;
		retire_rob_idx      = '0;
		mispredict          = 1'b0;
		mem_ack             = 1'b0;
		mem_rdata           = '0;
		repeat (5) @(posedge clock);
		#4;
		reset = 1'b0;

		test_reset_state();
		test_load_issue();
		test_store_report();
		test_store_load_order();
		test_full_flush();

		$display("Errors: %0d compare, %0d timeout", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end
endmodule

//--- verification/lsq_properties.sv
// LSQ protocol checks
// Concurrent assertions on the held memory request, dispatch while
// full and a known result strobe, bound onto the top level
`timescale 1ns/1ps

module lsq_properties import lsq_pkg::*; (
	input logic     clock,
	input logic     reset,
	input logic     mispredict,
	input logic     dispatch_valid,
	input logic     lsq_full,
	input logic     mem_ack,
	input bus_cmd_t mem_command,
	input word_t    mem_address,
	input logic     result_valid
);
	// Request stays put until mem_ack unless a flush drops it
	request_held: assert property (@(posedge clock) disable iff (reset)
		(mem_command != bus_none && !mem_ack && !mispredict)
			|=> (mem_command == $past(mem_command) && mem_address == $past(mem_address)))
		else $error("Memory request changed before mem_ack");

	no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
		!(dispatch_valid && lsq_full))
		else $error("Dispatch offered while the LSQ is full");

	result_known: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(result_valid))
		else $error("result_valid is unknown");
endmodule

//--- hw/lsq_top.sv
// Load/store queue top level
// Connects the load queue, the store queue and the arbiter to
// dispatch, CDB, ROB and the memory port
`timescale 1ns/1ps

module lsq_top import lsq_pkg::*; #(
	parameter int LQ_DEPTH = lsq_pkg::LQ_DEPTH,
	parameter int SQ_DEPTH = lsq_pkg::SQ_DEPTH
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     dispatch_valid,
	input  mem_op_t  dispatch_op,
	input  word_t    dispatch_base,
	input  logic     dispatch_base_ready,
	input  word_t    dispatch_offset,
	input  word_t    dispatch_data,
	input  logic     dispatch_data_ready,
	input  rob_idx_t dispatch_rob_idx,
	input  tag_t     dispatch_dest_tag,
	input  logic     cdb_valid,
	input  tag_t     cdb_tag,
	input  word_t    cdb_value,
	input  logic     retire_valid,
	input  rob_idx_t retire_rob_idx,
	input  logic     mispredict,
	output bus_cmd_t mem_command,
	output word_t    mem_address,
	output word_t    mem_wdata,
	input  logic     mem_ack,
	input  word_t    mem_rdata,
	output logic     result_valid,
	output rob_idx_t result_rob_idx,
	output tag_t     result_tag,
	output word_t    result_value,
	output logic     lsq_full
);
	typedef logic [$clog2(SQ_DEPTH):0] sq_ptr_t;

	// Load head
	logic     lq_head_valid;
	logic     lq_head_addr_ready;
	word_t    lq_head_address;
	logic     lq_head_done;
	word_t    lq_head_value;
	rob_idx_t lq_head_rob_idx;
	tag_t     lq_head_dest_tag;
	sq_ptr_t  lq_head_store_mark;
	logic     lq_full;
	// Store head and report
	sq_ptr_t  sq_tail_mark;
	sq_ptr_t  sq_head_mark;
	logic     sq_head_committed;
	word_t    sq_head_address;
	word_t    sq_head_data;
	logic     sq_report_pending;
	word_t    sq_report_address;
	rob_idx_t sq_report_rob_idx;
	logic     sq_full;
	// Arbiter controls
	logic     head_fill;
	logic     lq_head_release;
	logic     sq_head_release;
	logic     report_taken;

	load_queue #(.LQ_DEPTH(LQ_DEPTH), .SQ_DEPTH(SQ_DEPTH)) u_load_queue (
		.clock, .reset, .mispredict,
		.dispatch_valid, .dispatch_op, .dispatch_base, .dispatch_base_ready,
		.dispatch_offset, .dispatch_rob_idx, .dispatch_dest_tag,
		.sq_tail_mark,
		.cdb_valid, .cdb_tag, .cdb_value,
		.head_fill, .mem_rdata,
		.head_release     (lq_head_release),
		.head_valid       (lq_head_valid),
		.head_addr_ready  (lq_head_addr_ready),
		.head_address     (lq_head_address),
		.head_done        (lq_head_done),
		.head_value       (lq_head_value),
		.head_rob_idx     (lq_head_rob_idx),
		.head_dest_tag    (lq_head_dest_tag),
		.head_store_mark  (lq_head_store_mark),
		.full             (lq_full)
	);

	store_queue #(.SQ_DEPTH(SQ_DEPTH)) u_store_queue (
		.clock, .reset, .mispredict,
		.dispatch_valid, .dispatch_op, .dispatch_base, .dispatch_base_ready,
		.dispatch_offset, .dispatch_data, .dispatch_data_ready, .dispatch_rob_idx,
		.cdb_valid, .cdb_tag, .cdb_value,
		.retire_valid, .retire_rob_idx,
		.report_taken,
		.head_release     (sq_head_release),
		.tail_mark        (sq_tail_mark),
		.head_mark        (sq_head_mark),
		.head_committed   (sq_head_committed),
		.head_address     (sq_head_address),
		.head_data        (sq_head_data),
		.report_pending   (sq_report_pending),
		.report_address   (sq_report_address),
		.report_rob_idx   (sq_report_rob_idx),
		.full             (sq_full)
	);

	lsq_arbiter #(.SQ_DEPTH(SQ_DEPTH)) u_arbiter (
		.clock, .reset, .mispredict,
		.lq_head_valid, .lq_head_addr_ready, .lq_head_address, .lq_head_done,
		.lq_head_value, .lq_head_rob_idx, .lq_head_dest_tag, .lq_head_store_mark,
		.sq_head_mark, .sq_head_committed, .sq_head_address, .sq_head_data,
		.sq_report_pending, .sq_report_address, .sq_report_rob_idx,
		.mem_ack,
		.mem_command, .mem_address, .mem_wdata,
		.head_fill, .lq_head_release, .sq_head_release, .report_taken,
		.result_valid, .result_rob_idx, .result_tag, .result_value
	);

	assign lsq_full = lq_full || sq_full; // Either queue stops dispatch
endmodule

//--- hw/lsq_arbiter.sv
// LSQ arbiter
// Picks the memory request among the queue heads and holds it until
// acknowledged, and drives the single result port
`timescale 1ns/1ps

module lsq_arbiter import lsq_pkg::*; #(
	parameter int SQ_DEPTH = lsq_pkg::SQ_DEPTH
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      mispredict,
	input  logic                      lq_head_valid,
	input  logic                      lq_head_addr_ready,
	input  word_t                     lq_head_address,
	input  logic                      lq_head_done,
	input  word_t                     lq_head_value,
	input  rob_idx_t                  lq_head_rob_idx,
	input  tag_t                      lq_head_dest_tag,
	input  logic [$clog2(SQ_DEPTH):0] lq_head_store_mark,
	input  logic [$clog2(SQ_DEPTH):0] sq_head_mark,
	input  logic                      sq_head_committed,
	input  word_t                     sq_head_address,
	input  word_t                     sq_head_data,
	input  logic                      sq_report_pending,
	input  word_t                     sq_report_address,
	input  rob_idx_t                  sq_report_rob_idx,
	input  logic                      mem_ack,
	output bus_cmd_t                  mem_command,
	output word_t                     mem_address,
	output word_t                     mem_wdata,
	output logic                      head_fill,
	output logic                      lq_head_release,
	output logic                      sq_head_release,
	output logic                      report_taken,
	output logic                      result_valid,
	output rob_idx_t                  result_rob_idx,
	output tag_t                      result_tag,
	output word_t                     result_value
);
	logic busy;       // Request started and waiting for mem_ack
	logic held_store;
	logic store_go;
	logic load_go;
	logic sel_store;
	logic sel_load;
	logic load_result;

	assign store_go = sq_head_committed;
	// Load goes only when every older store has been written
	assign load_go  = lq_head_valid && lq_head_addr_ready && !lq_head_done
		&& (lq_head_store_mark == sq_head_mark);

	assign sel_store = busy ? held_store : store_go;
	assign sel_load  = busy ? !held_store : (!store_go && load_go);

	always_comb begin
		mem_command = bus_none;
		mem_address = '0;
		mem_wdata   = '0;
		if (sel_store) begin
			mem_command = bus_store;
			mem_address = sq_head_address;
			mem_wdata   = sq_head_data;
		end else if (sel_load) begin
			mem_command = bus_load;
			mem_address = lq_head_address;
		end
	end

	assign head_fill       = sel_load && mem_ack;
	assign sq_head_release = sel_store && mem_ack;

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			busy       <= 1'b0;
			held_store <= 1'b0;
		end else if (busy) begin
			if (mem_ack)
				busy <= 1'b0;
		end else if ((sel_store || sel_load) && !mem_ack) begin
			busy       <= 1'b1;
			held_store <= sel_store;
		end
	end

	//////////////////////////////
	// Result port
	//////////////////////////////
	assign load_result     = lq_head_valid && lq_head_done; // Load beats a store report
	assign lq_head_release = load_result;
	assign report_taken    = !load_result && sq_report_pending;
	assign result_valid    = load_result || sq_report_pending;
	assign result_rob_idx  = load_result ? lq_head_rob_idx : sq_report_rob_idx;
	assign result_tag      = load_result ? lq_head_dest_tag : STORE_TAG;
	assign result_value    = load_result ? lq_head_value : sq_report_address;
endmodule

//--- hw/store_queue.sv
// Store queue
// Circular array of store entries. Head leaves on a memory write, tail
// takes dispatches and the report pointer walks the stores in order
`timescale 1ns/1ps

module store_queue import lsq_pkg::*; #(
	parameter int SQ_DEPTH = lsq_pkg::SQ_DEPTH
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      mispredict,
	input  logic                      dispatch_valid,
	input  mem_op_t                   dispatch_op,
	input  word_t                     dispatch_base,
	input  logic                      dispatch_base_ready,
	input  word_t                     dispatch_offset,
	input  word_t                     dispatch_data,
	input  logic                      dispatch_data_ready,
	input  rob_idx_t                  dispatch_rob_idx,
	input  logic                      cdb_valid,
	input  tag_t                      cdb_tag,
	input  word_t                     cdb_value,
	input  logic                      retire_valid,
	input  rob_idx_t                  retire_rob_idx,
	input  logic                      report_taken,
	input  logic                      head_release,
	output logic [$clog2(SQ_DEPTH):0] tail_mark,
	output logic [$clog2(SQ_DEPTH):0] head_mark,
	output logic                      head_committed,
	output word_t                     head_address,
	output word_t                     head_data,
	output logic                      report_pending,
	output word_t                     report_address,
	output rob_idx_t                  report_rob_idx,
	output logic                      full
);
	localparam int SQ_BITS = $clog2(SQ_DEPTH);
	typedef logic [SQ_BITS:0] sq_ptr_t;

	sq_ptr_t            head;
	sq_ptr_t            tail;
	sq_ptr_t            rpt;
	logic [SQ_BITS-1:0] head_slot;
	logic [SQ_BITS-1:0] tail_slot;
	logic [SQ_BITS-1:0] rpt_slot;
	logic               alloc_store;

	logic     entry_busy      [SQ_DEPTH];
	logic     entry_ready     [SQ_DEPTH];
	word_t    entry_address   [SQ_DEPTH];
	word_t    entry_data      [SQ_DEPTH];
	rob_idx_t entry_rob_idx   [SQ_DEPTH];
	logic     entry_reported  [SQ_DEPTH];
	logic     entry_committed [SQ_DEPTH];

	assign head_slot   = head[SQ_BITS-1:0];
	assign tail_slot   = tail[SQ_BITS-1:0];
	assign rpt_slot    = rpt[SQ_BITS-1:0];
	assign alloc_store = dispatch_valid && (dispatch_op == op_store) && !full && !mispredict;
	assign full        = (tail[SQ_BITS] != head[SQ_BITS]) && (tail_slot == head_slot);

	for (genvar i = 0; i < SQ_DEPTH; i++) begin : g_entry
		sq_entry u_entry (
			.clock            (clock),
			.reset            (reset),
			.flush            (mispredict),
			.alloc            (alloc_store && (tail_slot == SQ_BITS'(i))),
			.alloc_base       (dispatch_base),
			.alloc_base_ready (dispatch_base_ready),
			.alloc_offset     (dispatch_offset),
			.alloc_data       (dispatch_data),
			.alloc_data_ready (dispatch_data_ready),
			.alloc_rob_idx    (dispatch_rob_idx),
			.cdb_valid        (cdb_valid),
			.cdb_tag          (cdb_tag),
			.cdb_value        (cdb_value),
			.reported_set     (report_taken && (rpt_slot == SQ_BITS'(i))),
			.retire_valid     (retire_valid),
			.retire_rob_idx   (retire_rob_idx),
			.release_en       (head_release && (head_slot == SQ_BITS'(i))),
			.busy             (entry_busy[i]),
			.ready            (entry_ready[i]),
			.address          (entry_address[i]),
			.store_data       (entry_data[i]),
			.rob_idx          (entry_rob_idx[i]),
			.reported         (entry_reported[i]),
			.committed        (entry_committed[i])
		);
	end

	//////////////////////////////
	// Pointers
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			rpt  <= '0;
		end else if (mispredict) begin
			tail <= head;
			rpt  <= head;
		end else begin
			if (alloc_store)
				tail <= tail + 1'b1;
			if (head_release)
				head <= head + 1'b1;
			if (report_taken)
				rpt <= rpt + 1'b1;
		end
	end

	assign tail_mark      = tail;
	assign head_mark      = head; // Equals a load's mark once its older stores are gone
	assign head_committed = entry_busy[head_slot] && entry_committed[head_slot];
	assign head_address   = entry_address[head_slot];
	assign head_data      = entry_data[head_slot];

	// Oldest unreported store is shown once its operands are in
	assign report_pending = entry_ready[rpt_slot] && !entry_reported[rpt_slot];
	assign report_address = entry_address[rpt_slot];
	assign report_rob_idx = entry_rob_idx[rpt_slot];
endmodule

//--- hw/load_queue.sv
// Load queue
// Circular array of load entries run by head and tail pointers. Loads
// allocate at the tail, memory fills and releases go to the head
`timescale 1ns/1ps

module load_queue import lsq_pkg::*; #(
	parameter int LQ_DEPTH = lsq_pkg::LQ_DEPTH,
	parameter int SQ_DEPTH = lsq_pkg::SQ_DEPTH
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      mispredict,
	input  logic                      dispatch_valid,
	input  mem_op_t                   dispatch_op,
	input  word_t                     dispatch_base,
	input  logic                      dispatch_base_ready,
	input  word_t                     dispatch_offset,
	input  rob_idx_t                  dispatch_rob_idx,
	input  tag_t                      dispatch_dest_tag,
	input  logic [$clog2(SQ_DEPTH):0] sq_tail_mark,
	input  logic                      cdb_valid,
	input  tag_t                      cdb_tag,
	input  word_t                     cdb_value,
	input  logic                      head_fill,
	input  word_t                     mem_rdata,
	input  logic                      head_release,
	output logic                      head_valid,
	output logic                      head_addr_ready,
	output word_t                     head_address,
	output logic                      head_done,
	output word_t                     head_value,
	output rob_idx_t                  head_rob_idx,
	output tag_t                      head_dest_tag,
	output logic [$clog2(SQ_DEPTH):0] head_store_mark,
	output logic                      full
);
	localparam int LQ_BITS = $clog2(LQ_DEPTH);
	typedef logic [LQ_BITS:0]          lq_ptr_t; // Extra wrap bit
	typedef logic [$clog2(SQ_DEPTH):0] sq_ptr_t;

	lq_ptr_t            head;
	lq_ptr_t            tail;
	logic [LQ_BITS-1:0] head_slot;
	logic [LQ_BITS-1:0] tail_slot;
	logic               alloc_load;

	logic     entry_busy       [LQ_DEPTH];
	logic     entry_addr_ready [LQ_DEPTH];
	word_t    entry_address    [LQ_DEPTH];
	logic     entry_done       [LQ_DEPTH];
	word_t    entry_value      [LQ_DEPTH];
	rob_idx_t entry_rob_idx    [LQ_DEPTH];
	tag_t     entry_dest_tag   [LQ_DEPTH];
	sq_ptr_t  entry_mark       [LQ_DEPTH];

	assign head_slot  = head[LQ_BITS-1:0];
	assign tail_slot  = tail[LQ_BITS-1:0];
	assign alloc_load = dispatch_valid && (dispatch_op == op_load) && !full && !mispredict;
	assign full       = (tail[LQ_BITS] != head[LQ_BITS]) && (tail_slot == head_slot);

	for (genvar i = 0; i < LQ_DEPTH; i++) begin : g_entry
		lq_entry #(.SQ_DEPTH(SQ_DEPTH)) u_entry (
			.clock            (clock),
			.reset            (reset),
			.flush            (mispredict),
			.alloc            (alloc_load && (tail_slot == LQ_BITS'(i))),
			.alloc_base       (dispatch_base),
			.alloc_base_ready (dispatch_base_ready),
			.alloc_offset     (dispatch_offset),
			.alloc_rob_idx    (dispatch_rob_idx),
			.alloc_dest_tag   (dispatch_dest_tag),
			.alloc_store_mark (sq_tail_mark),
			.cdb_valid        (cdb_valid),
			.cdb_tag          (cdb_tag),
			.cdb_value        (cdb_value),
			.fill             (head_fill && (head_slot == LQ_BITS'(i))),
			.fill_data        (mem_rdata),
			.release_en       (head_release && (head_slot == LQ_BITS'(i))),
			.busy             (entry_busy[i]),
			.addr_ready       (entry_addr_ready[i]),
			.address          (entry_address[i]),
			.done             (entry_done[i]),
			.load_value       (entry_value[i]),
			.rob_idx          (entry_rob_idx[i]),
			.dest_tag         (entry_dest_tag[i]),
			.store_mark       (entry_mark[i])
		);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
		end else if (mispredict) begin
			tail <= head; // Queue empties as every entry flushes
		end else begin
			if (alloc_load)
				tail <= tail + 1'b1;
			if (head_release)
				head <= head + 1'b1;
		end
	end

	assign head_valid      = entry_busy[head_slot];
	assign head_addr_ready = entry_addr_ready[head_slot];
	assign head_address    = entry_address[head_slot];
	assign head_done       = entry_done[head_slot];
	assign head_value      = entry_value[head_slot];
	assign head_rob_idx    = entry_rob_idx[head_slot];
	assign head_dest_tag   = entry_dest_tag[head_slot];
	assign head_store_mark = entry_mark[head_slot];
endmodule

//--- hw/sq_entry.sv
// Store queue entry
// Holds one store, captures base and data from the CDB on their own,
// and tracks whether it was reported and then retired by the ROB
`timescale 1ns/1ps

module sq_entry import lsq_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     flush,
	input  logic     alloc,
	input  word_t    alloc_base,
	input  logic     alloc_base_ready,
	input  word_t    alloc_offset,
	input  word_t    alloc_data,
	input  logic     alloc_data_ready,
	input  rob_idx_t alloc_rob_idx,
	input  logic     cdb_valid,
	input  tag_t     cdb_tag,
	input  word_t    cdb_value,
	input  logic     reported_set,
	input  logic     retire_valid,
	input  rob_idx_t retire_rob_idx,
	input  logic     release_en,
	output logic     busy,
	output logic     ready,
	output word_t    address,
	output word_t    store_data,
	output rob_idx_t rob_idx,
	output logic     reported,
	output logic     committed
);
	word_t base;
	word_t offset;
	logic  base_ready;
	logic  data_ready;
	logic  base_alloc_hit;
	logic  data_alloc_hit;
	logic  base_hit;
	logic  data_hit;

	assign base_alloc_hit = cdb_valid && !alloc_base_ready && (cdb_tag == tag_t'(alloc_base));
	assign data_alloc_hit = cdb_valid && !alloc_data_ready && (cdb_tag == tag_t'(alloc_data));
	assign base_hit       = cdb_valid && busy && !base_ready && (cdb_tag == tag_t'(base));
	assign data_hit       = cdb_valid && busy && !data_ready && (cdb_tag == tag_t'(store_data));

	always_ff @(posedge clock) begin
		if (reset || flush || release_en) begin
			busy       <= 1'b0;
			base_ready <= 1'b0;
			data_ready <= 1'b0;
			reported   <= 1'b0;
			committed  <= 1'b0;
		end else if (alloc) begin
			busy       <= 1'b1;
			base_ready <= alloc_base_ready || base_alloc_hit;
			data_ready <= alloc_data_ready || data_alloc_hit;
			reported   <= 1'b0;
			committed  <= 1'b0;
		end else begin
			if (base_hit)
				base_ready <= 1'b1;
			if (data_hit)
				data_ready <= 1'b1;
			if (reported_set)
				reported <= 1'b1;
			// ROB retires a store only once its report went out
			if (busy && reported && retire_valid && (retire_rob_idx == rob_idx))
				committed <= 1'b1;
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		if (alloc) begin
			base       <= base_alloc_hit ? cdb_value : alloc_base;
			store_data <= data_alloc_hit ? cdb_value : alloc_data;
			offset     <= alloc_offset;
			rob_idx    <= alloc_rob_idx;
		end else begin
			if (base_hit)
				base <= cdb_value;
			if (data_hit)
				store_data <= cdb_value;
		end
	end

	assign ready   = busy && base_ready && data_ready;
	assign address = base + offset;
endmodule

//--- hw/lq_entry.sv
// Load queue entry
// Holds one load, snoops the CDB for a pending base and keeps the
// value returned by memory until the queue frees the slot
`timescale 1ns/1ps

module lq_entry import lsq_pkg::*; #(
	parameter int SQ_DEPTH = lsq_pkg::SQ_DEPTH
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      flush,
	input  logic                      alloc,
	input  word_t                     alloc_base,
	input  logic                      alloc_base_ready,
	input  word_t                     alloc_offset,
	input  rob_idx_t                  alloc_rob_idx,
	input  tag_t                      alloc_dest_tag,
	input  logic [$clog2(SQ_DEPTH):0] alloc_store_mark,
	input  logic                      cdb_valid,
	input  tag_t                      cdb_tag,
	input  word_t                     cdb_value,
	input  logic                      fill,
	input  word_t                     fill_data,
	input  logic                      release_en,
	output logic                      busy,
	output logic                      addr_ready,
	output word_t                     address,
	output logic                      done,
	output word_t                     load_value,
	output rob_idx_t                  rob_idx,
	output tag_t                      dest_tag,
	output logic [$clog2(SQ_DEPTH):0] store_mark
);
	word_t base;
	word_t offset;
	logic  base_ready;
	logic  alloc_hit;
	logic  base_hit;

	// A pending base carries its producer tag in the low bits
	assign alloc_hit = cdb_valid && !alloc_base_ready && (cdb_tag == tag_t'(alloc_base));
	assign base_hit  = cdb_valid && busy && !base_ready && (cdb_tag == tag_t'(base));

	always_ff @(posedge clock) begin
		if (reset || flush || release_en) begin
			busy       <= 1'b0;
			base_ready <= 1'b0;
			done       <= 1'b0;
		end else if (alloc) begin
			busy       <= 1'b1;
			base_ready <= alloc_base_ready || alloc_hit; // CDB seen in the dispatch cycle
			done       <= 1'b0;
		end else begin
			if (base_hit)
				base_ready <= 1'b1;
			if (fill)
				done <= 1'b1;
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		if (alloc) begin
			base       <= alloc_hit ? cdb_value : alloc_base;
			offset     <= alloc_offset;
			rob_idx    <= alloc_rob_idx;
			dest_tag   <= alloc_dest_tag;
			store_mark <= alloc_store_mark; // SQ tail at dispatch
		end else if (base_hit) begin
			base <= cdb_value;
		end
		if (fill)
			load_value <= fill_data;
	end

	assign addr_ready = busy && base_ready;
	assign address    = base + offset;
endmodule

//--- hw/lsq_pkg.sv
// LSQ shared definitions
// Word, tag and ROB index widths, the dispatch and memory command
// encodings and the default queue depths
package lsq_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////
	typedef logic [63:0] word_t;    // Data or address word
	typedef logic [5:0]  tag_t;     // Physical register tag for 64 registers
	typedef logic [4:0]  rob_idx_t; // ROB slot

	//////////////////////////////
	// Encodings
	//////////////////////////////
	typedef enum logic [1:0] {
		op_none,
		op_load,
		op_store
	} mem_op_t;

	typedef enum logic [1:0] {
		bus_none,
		bus_load,
		bus_store
	} bus_cmd_t;

	// Default depths that may be any power of two from 2 up
	parameter int LQ_DEPTH = 8;
	parameter int SQ_DEPTH = 8;

	// Destination tag shown with a store report
	localparam tag_t STORE_TAG = '0;

endpackage
